// File: design/hdr_proc_pkg.sv
`default_nettype none

// ==================================================
// shared types for the header processing pipeline.
// ==================================================
package hdr_proc_pkg;

   // bytes carried by one stream beat.
   localparam int data_bytes = 8;

   // byte 0 of the beat payload sits in bits 7..0.
   typedef logic [data_bytes*8-1:0] beat_data_t;

   // byte enables are always contiguous from bit 0.
   typedef logic [data_bytes-1:0] beat_keep_t;

   // one stream beat as it moves between stages.
   typedef struct packed {
      beat_data_t data;
      beat_keep_t keep;
      logic       last;
   } axis_beat_t;

   // handling of a packet whose first beat matches the drop pattern.
   typedef enum logic {
      // packet shrinks to a single empty last beat.
      drop_mark,
      // packet disappears from the stream.
      drop_whole
   } drop_mode_t;

   // truncation stage states.
   typedef enum logic {
      // beats go to the output register.
      trunc_pass,
      // tail of the packet is swallowed.
      trunc_discard
   } trunc_state_t;

   // byte length and byte position within a packet.
   typedef logic [15:0] hdr_len_t;

endpackage

`default_nettype wire

// File: design/hdr_drop_filter.sv
`timescale 1ns/1ns
`default_nettype none

module hdr_drop_filter (
   input  logic                     axi4s_in,
   input  logic                     srst,
   input  logic                     in_valid,
   output logic                     in_ready,
   input  hdr_proc_pkg::axis_beat_t in_beat,
   output logic                     out_valid,
   input  logic                     out_ready,
   output hdr_proc_pkg::axis_beat_t out_beat,
   input  logic                     drop_enable,
   input  hdr_proc_pkg::beat_data_t drop_pattern,
   input  hdr_proc_pkg::drop_mode_t drop_mode
);
   import hdr_proc_pkg::*;

   logic running;
   logic first_beat;
   logic drop_active;
   logic match;
   logic silent;
   logic take;

   // ==================================================
   // match and handshake.
   // ==================================================
   // only the first beat of a packet is compared.
   assign match = first_beat && drop_enable && (in_beat.data == drop_pattern);

   // beats that never reach the output register.
   assign silent = drop_active || (match && (drop_mode == drop_whole));

   // input is held off until the cycle after reset.
   // silent beats are taken whatever the output register holds.
   assign in_ready = running && (silent || !out_valid || out_ready);
   assign take = in_valid && in_ready;

   // ==================================================
   // control state.
   // ==================================================
   always_ff @(posedge axi4s_in) begin
      if (srst) begin
         running     <= 1'b0;
         first_beat  <= 1'b1;
         drop_active <= 1'b0;
         out_valid   <= 1'b0;
      end else begin
         running <= 1'b1;
         if (out_valid && out_ready) begin
            out_valid <= 1'b0;
         end
         if (take) begin
            // next beat opens a packet after every last.
            first_beat <= in_beat.last;
            if (in_beat.last) begin
               drop_active <= 1'b0;
            end else if (match) begin
               drop_active <= 1'b1;
            end
            if (!silent) begin
               out_valid <= 1'b1;
            end
         end
      end
   end

   // a marked beat enters the output register as an empty last beat.
   always_ff @(posedge axi4s_in) begin
      if (take && !silent) begin
         out_beat.data <= in_beat.data;
         out_beat.keep <= match ? '0 : in_beat.keep;
         out_beat.last <= match ? 1'b1 : in_beat.last;
      end
   end

endmodule

`default_nettype wire

// File: design/hdr_prefix_insert.sv
`timescale 1ns/1ns
`default_nettype none

module hdr_prefix_insert #(
   parameter int max_prefix_words = 4
) (
   input  logic                     axi4s_in,
   input  logic                     srst,
   input  logic                     in_valid,
   output logic                     in_ready,
   input  hdr_proc_pkg::axis_beat_t in_beat,
   output logic                     out_valid,
   input  logic                     out_ready,
   output hdr_proc_pkg::axis_beat_t out_beat,
   input  logic [$clog2(max_prefix_words+1)-1:0]          prefix_words,
   input  hdr_proc_pkg::beat_data_t [max_prefix_words-1:0] prefix_data
);
   import hdr_proc_pkg::*;

   localparam int idx_w = $clog2(max_prefix_words + 1);

   logic [idx_w-1:0] word_idx;
   logic             add_prefix;
   logic             space;
   logic             load;
   beat_data_t       prefix_word;
   axis_beat_t       next_beat;

   // ==================================================
   // prefix selection.
   // ==================================================
   // prefix words still owed to the current packet.
   assign add_prefix = word_idx < prefix_words;

   // output register free now or at this edge.
   assign space = !out_valid || out_ready;

   // input waits while prefix words go out.
   assign in_ready = space && !add_prefix;

   // prefix emission starts only once a packet is waiting.
   assign load = in_valid && space;

   always_comb begin
      prefix_word = '0;
      for (int i = 0; i < max_prefix_words; i++) begin
         if (word_idx == idx_w'(i)) begin
            prefix_word = prefix_data[i];
         end
      end
   end

   // prefix words are full beats and never close a packet.
   always_comb begin
      next_beat = in_beat;
      if (add_prefix) begin
         next_beat.data = prefix_word;
         next_beat.keep = '1;
         next_beat.last = 1'b0;
      end
   end

   // ==================================================
   // word index and output register.
   // ==================================================
   always_ff @(posedge axi4s_in) begin
      if (srst) begin
         word_idx  <= '0;
         out_valid <= 1'b0;
      end else begin
         if (out_valid && out_ready) begin
            out_valid <= 1'b0;
         end
         if (load) begin
            out_valid <= 1'b1;
            if (add_prefix) begin
               word_idx <= word_idx + idx_w'(1);
            end else if (in_beat.last) begin
               // rearm for the next packet.
               word_idx <= '0;
            end
         end
      end
   end

   always_ff @(posedge axi4s_in) begin
      if (load) begin
         out_beat <= next_beat;
      end
   end

endmodule

`default_nettype wire

// File: design/hdr_truncate.sv
`timescale 1ns/1ns
`default_nettype none

module hdr_truncate (
   input  logic                     axi4s_in,
   input  logic                     srst,
   input  logic                     in_valid,
   output logic                     in_ready,
   input  hdr_proc_pkg::axis_beat_t in_beat,
   output logic                     out_valid,
   input  logic                     out_ready,
   output hdr_proc_pkg::axis_beat_t out_beat,
   input  hdr_proc_pkg::hdr_len_t   trunc_length
);
   import hdr_proc_pkg::*;

   trunc_state_t state;
   hdr_len_t     byte_cnt;
   hdr_len_t     beat_bytes;
   hdr_len_t     next_cnt;
   hdr_len_t     remain;
   logic         cut;
   logic         take;
   axis_beat_t   next_beat;

   // ==================================================
   // length tracking.
   // ==================================================
   // keep is contiguous, so its popcount is the byte count.
   assign beat_bytes = hdr_len_t'($countones(in_beat.keep));
   assign next_cnt = byte_cnt + beat_bytes;
   assign remain = trunc_length - byte_cnt;

   // zero length leaves packets alone.
   assign cut = (trunc_length != '0) && (next_cnt >= trunc_length);

   // discarding never needs the output register.
   assign in_ready = (state == trunc_discard) || !out_valid || out_ready;
   assign take = in_valid && in_ready;

   // cut beat keeps only the bytes up to the length.
   always_comb begin
      next_beat = in_beat;
      if (cut) begin
         next_beat.last = 1'b1;
         for (int i = 0; i < data_bytes; i++) begin
            next_beat.keep[i] = in_beat.keep[i] && (hdr_len_t'(i) < remain);
         end
      end
   end

   // ==================================================
   // state machine and output register.
   // ==================================================
   always_ff @(posedge axi4s_in) begin
      if (srst) begin
         state     <= trunc_pass;
         byte_cnt  <= '0;
         out_valid <= 1'b0;
      end else begin
         if (out_valid && out_ready) begin
            out_valid <= 1'b0;
         end
         if (take) begin
            if (state == trunc_discard) begin
               if (in_beat.last) begin
                  state <= trunc_pass;
               end
            end else begin
               out_valid <= 1'b1;
               byte_cnt  <= (in_beat.last || cut) ? '0 : next_cnt;
               if (cut && !in_beat.last) begin
                  state <= trunc_discard;
               end
            end
         end
      end
   end

   always_ff @(posedge axi4s_in) begin
      if (take && (state == trunc_pass)) begin
         out_beat <= next_beat;
      end
   end

endmodule

`default_nettype wire

// File: design/hdr_pkt_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module hdr_pkt_fifo #(
   parameter int fifo_depth = 32
) (
   input  logic                     axi4s_in,
   input  logic                     srst,
   input  logic                     in_valid,
   output logic                     in_ready,
   input  hdr_proc_pkg::axis_beat_t in_beat,
   output logic                     out_valid,
   input  logic                     out_ready,
   output hdr_proc_pkg::axis_beat_t out_beat
);
   import hdr_proc_pkg::*;

   localparam int ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
   localparam int cnt_w = $clog2(fifo_depth + 1);

   axis_beat_t       mem [fifo_depth];
   logic [ptr_w-1:0] wr_ptr;
   logic [ptr_w-1:0] rd_ptr;
   logic [cnt_w-1:0] count;
   logic             wr_en;
   logic             rd_en;

   // circular pointer step.
   function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
      return (ptr == ptr_w'(fifo_depth - 1)) ? '0 : ptr + ptr_w'(1);
   endfunction

   assign in_ready = count != cnt_w'(fifo_depth);
   assign wr_en = in_valid && in_ready;

   // move a stored beat into the output register when it frees up.
   assign rd_en = (count != '0) && (!out_valid || out_ready);

   // ==================================================
   // pointers and occupancy.
   // ==================================================
   always_ff @(posedge axi4s_in) begin
      if (srst) begin
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         count     <= '0;
         out_valid <= 1'b0;
      end else begin
         if (wr_en) begin
            wr_ptr <= next_ptr(wr_ptr);
         end
         if (rd_en) begin
            rd_ptr <= next_ptr(rd_ptr);
         end
         if (wr_en && !rd_en) begin
            count <= count + cnt_w'(1);
         end else if (!wr_en && rd_en) begin
            count <= count - cnt_w'(1);
         end
         if (rd_en) begin
            out_valid <= 1'b1;
         end else if (out_ready) begin
            out_valid <= 1'b0;
         end
      end
   end

   // beat storage and registered read.
   always_ff @(posedge axi4s_in) begin
      if (wr_en) begin
         mem[wr_ptr] <= in_beat;
      end
      if (rd_en) begin
         out_beat <= mem[rd_ptr];
      end
   end

endmodule

`default_nettype wire

// File: design/hdr_proc_top.sv
`timescale 1ns/1ns
`default_nettype none

module hdr_proc_top #(
   parameter int fifo_depth       = 32,
   parameter int max_prefix_words = 4
) (
   input  logic                     axi4s_in,
   input  logic                     srst,
   input  logic                     s_valid,
   output logic                     s_ready,
   input  hdr_proc_pkg::axis_beat_t s_beat,
   output logic                     m_valid,
   input  logic                     m_ready,
   output hdr_proc_pkg::axis_beat_t m_beat,
   input  logic                     drop_enable,
   input  hdr_proc_pkg::beat_data_t drop_pattern,
   input  hdr_proc_pkg::drop_mode_t drop_mode,
   input  logic [$clog2(max_prefix_words+1)-1:0]          prefix_words,
   input  hdr_proc_pkg::beat_data_t [max_prefix_words-1:0] prefix_data,
   input  hdr_proc_pkg::hdr_len_t   trunc_length
);
   import hdr_proc_pkg::*;

   // links between the stages, in stream order.
   logic       filter_valid;
   logic       filter_ready;
   axis_beat_t filter_beat;
   logic       prefix_valid;
   logic       prefix_ready;
   axis_beat_t prefix_beat;
   logic       trunc_valid;
   logic       trunc_ready;
   axis_beat_t trunc_beat;

   // ==================================================
   // drop, prefix, truncate, then buffer.
   // ==================================================
   hdr_drop_filter u_filter (
      .axi4s_in, .srst,
      .in_valid  (s_valid),      .in_ready  (s_ready),      .in_beat  (s_beat),
      .out_valid (filter_valid), .out_ready (filter_ready), .out_beat (filter_beat),
      .drop_enable, .drop_pattern, .drop_mode
   );

   hdr_prefix_insert #(.max_prefix_words(max_prefix_words)) u_prefix (
      .axi4s_in, .srst,
      .in_valid  (filter_valid), .in_ready  (filter_ready), .in_beat  (filter_beat),
      .out_valid (prefix_valid), .out_ready (prefix_ready), .out_beat (prefix_beat),
      .prefix_words, .prefix_data
   );

   hdr_truncate u_trunc (
      .axi4s_in, .srst,
      .in_valid  (prefix_valid), .in_ready  (prefix_ready), .in_beat  (prefix_beat),
      .out_valid (trunc_valid),  .out_ready (trunc_ready),  .out_beat (trunc_beat),
      .trunc_length
   );

   hdr_pkt_fifo #(.fifo_depth(fifo_depth)) u_fifo (
      .axi4s_in, .srst,
      .in_valid  (trunc_valid),  .in_ready  (trunc_ready),  .in_beat  (trunc_beat),
      .out_valid (m_valid),      .out_ready (m_ready),      .out_beat (m_beat)
   );

endmodule

`default_nettype wire

// File: tests/tb_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
   output logic axi4s_in,
   output logic srst
);

   // 8 ns period.
   initial begin
      axi4s_in = 1'b0;
      forever #4 axi4s_in = ~axi4s_in;
   end

   // reset covers three rising edges and drops just after the third.
   initial begin
      srst = 1'b1;
      repeat (3) @(posedge axi4s_in);
      #1;
      srst = 1'b0;
   end

endmodule

`default_nettype wire

// File: tests/hdr_proc_chk.sv
`timescale 1ns/1ns
`default_nettype none

module hdr_proc_chk (
   input logic                     axi4s_in,
   input logic                     srst,
   input logic                     m_valid,
   input logic                     m_ready,
   input hdr_proc_pkg::axis_beat_t m_beat
);

   // ==================================================
   // output stream rules.
   // ==================================================
   // a stalled beat holds until it is taken.
   stall_stable: assert property (@(posedge axi4s_in) disable iff (srst)
      m_valid && !m_ready |=> m_valid && $stable(m_beat))
      else $error("m_valid or m_beat changed while waiting for m_ready");

   // the cycle after a reset edge has no valid output.
   reset_quiet: assert property (@(posedge axi4s_in) $past(srst) |-> !m_valid)
      else $error("m_valid high during reset");

   // only a closing beat may be empty.
   keep_present: assert property (@(posedge axi4s_in) disable iff (srst)
      m_valid |-> (m_beat.keep != '0) || m_beat.last)
      else $error("empty beat without last on the output");

endmodule

bind hdr_proc_top hdr_proc_chk u_chk (
   .axi4s_in, .srst, .m_valid, .m_ready, .m_beat
);

`default_nettype wire

// File: tests/hdr_proc_tb.sv
`timescale 1ns/1ns
`default_nettype none

module hdr_proc_tb;
   import hdr_proc_pkg::*;

   typedef logic [7:0] byte_q_t [$];

   logic                  axi4s_in;
   logic                  srst;
   logic                  s_valid;
   logic                  s_ready;
   axis_beat_t            s_beat;
   logic                  m_valid;
   logic                  m_ready;
   axis_beat_t            m_beat;
   logic                  drop_enable;
   beat_data_t            drop_pattern;
   drop_mode_t            drop_mode;
   logic [2:0]            prefix_words;
   beat_data_t [3:0]      prefix_data;
   hdr_len_t              trunc_length;

   // expected packets kept as flat byte, length and empty-tail queues.
   logic [7:0] exp_bytes [$];
   int         exp_len [$];
   bit         exp_empty [$];
   logic [7:0] got [$];
   bit         bp_mode;
   int         errors;
   int         errors_at_start;
   int         tests_run;
   int         tests_ok;
   int         sent_beats;
   int         cycle_cnt;

   tb_clock_gen u_clock (.axi4s_in, .srst);

   hdr_proc_top UUT (
      .axi4s_in, .srst,
      .s_valid, .s_ready, .s_beat,
      .m_valid, .m_ready, .m_beat,
      .drop_enable, .drop_pattern, .drop_mode,
      .prefix_words, .prefix_data,
      .trunc_length
   );

   // ==================================================
   // reference model applying drop, then prefix, then truncate.
   // ==================================================
   function automatic byte_q_t expect_packet(input byte_q_t pkt, output bit dropped,
                                             output bit empty_tail);
      byte_q_t    res;
      beat_data_t first;
      bit         marked;
      int         pre_len;
      first = '0;
      for (int i = 0; i < data_bytes && i < pkt.size(); i++) begin
         first[i*8 +: 8] = pkt[i];
      end
      marked = drop_enable && (first == drop_pattern);
      dropped = marked && (drop_mode == drop_whole);
      empty_tail = 1'b0;
      if (dropped) begin
         return res;
      end
      pre_len = int'(prefix_words) * data_bytes;
      for (int w = 0; w < int'(prefix_words); w++) begin
         for (int b = 0; b < data_bytes; b++) begin
            res.push_back(prefix_data[w][b*8 +: 8]);
         end
      end
      // a marked packet keeps only its empty closing beat, unless the cut lands first.
      if (marked) begin
         empty_tail = (trunc_length == '0) || (int'(trunc_length) > pre_len);
      end else begin
         foreach (pkt[i]) res.push_back(pkt[i]);
      end
      while (trunc_length != '0 && res.size() > int'(trunc_length)) begin
         void'(res.pop_back());
      end
      return res;
   endfunction

   // random bytes where a matching packet opens with the drop pattern.
   function automatic byte_q_t make_packet(input int n, input bit match);
      byte_q_t pkt;
      for (int i = 0; i < n; i++) begin
         if (match && i < data_bytes) begin
            pkt.push_back(drop_pattern[i*8 +: 8]);
         end else begin
            pkt.push_back(8'($urandom));
         end
      end
      return pkt;
   endfunction

   // ==================================================
   // stimulus tasks are called one ns after a rising edge.
   // ==================================================
   task automatic send_beat(input axis_beat_t beat);
      bit accepted;
      s_valid = 1'b1;
      s_beat = beat;
      // s_ready is settled a ns after the inputs change.
      do begin
         #1;
         accepted = s_ready;
         @(posedge axi4s_in);
         #1;
      end while (!accepted);
   endtask

   task automatic send_packet(input byte_q_t pkt);
      byte_q_t    want;
      bit         dropped;
      bit         empty;
      axis_beat_t beat;
      int         nbeats;
      want = expect_packet(pkt, dropped, empty);
      if (!dropped) begin
         foreach (want[i]) exp_bytes.push_back(want[i]);
         exp_len.push_back(want.size());
         exp_empty.push_back(empty);
      end
      nbeats = (pkt.size() + data_bytes - 1) / data_bytes;
      sent_beats += nbeats + (dropped ? 0 : int'(prefix_words));
      for (int k = 0; k < nbeats; k++) begin
         beat = '0;
         for (int b = 0; b < data_bytes; b++) begin
            if (k*data_bytes + b < pkt.size()) begin
               beat.data[b*8 +: 8] = pkt[k*data_bytes + b];
               beat.keep[b] = 1'b1;
            end
         end
         beat.last = (k == nbeats - 1);
         send_beat(beat);
      end
      s_valid = 1'b0;
   endtask

   // waits for every expected packet, then lets truncated tails clear.
   task automatic drain_pipeline();
      s_valid = 1'b0;
      while (exp_len.size() != 0) @(posedge axi4s_in);
      repeat (8) @(posedge axi4s_in);
      #1;
   endtask

   task automatic close_test(input string name);
      drain_pipeline();
      tests_run++;
      if (errors == errors_at_start) begin
         tests_ok++;
         $display("test %s: ok", name);
      end else begin
         $display("test %s: FAILED", name);
      end
      errors_at_start = errors;
   endtask

   // ==================================================
   // comparison.
   // ==================================================
   task automatic check_packet(input beat_keep_t last_keep);
      int         n;
      bit         empty;
      logic [7:0] want;
      assert (exp_len.size() != 0) else begin
         $display("output packet arrived while none was expected");
         errors++;
      end
      if (exp_len.size() != 0) begin
         n = exp_len.pop_front();
         empty = exp_empty.pop_front();
         assert (got.size() == n) else begin
            $display("CHECK FAILED m_beat packet bytes: got %h expected %h", got.size(), n);
            errors++;
         end
         for (int i = 0; i < n; i++) begin
            want = exp_bytes.pop_front();
            if (i < got.size()) begin
               assert (got[i] == want) else begin
                  $display("CHECK FAILED m_beat byte %0d: got %h expected %h", i, got[i], want);
                  errors++;
               end
            end
         end
         assert ((last_keep == '0) == empty) else begin
            $display("CHECK FAILED m_beat.keep on last beat: got %h expected empty %h",
                     last_keep, empty);
            errors++;
         end
      end
      got = {};
   endtask

   // outputs are read mid-cycle, where they are stable.
   always @(negedge axi4s_in) begin
      if (srst) begin
         // the input side stays closed while reset is held.
         assert (!s_ready) else begin
            $display("CHECK FAILED s_ready during reset: got %h expected 0", s_ready);
            errors++;
         end
      end else if (m_valid && m_ready) begin
         for (int b = 0; b < data_bytes; b++) begin
            if (m_beat.keep[b]) got.push_back(m_beat.data[b*8 +: 8]);
         end
         if (m_beat.last) check_packet(m_beat.keep);
      end
   end

   // sink that stalls at random while bp_mode is set.
   initial begin
      m_ready = 1'b0;
      forever begin
         @(posedge axi4s_in);
         #1;
         m_ready = bp_mode ? ($urandom_range(3) != 0) : 1'b1;
      end
   end

   // limit grows with the beats pushed into the pipeline.
   initial begin
      cycle_cnt = 0;
      while (cycle_cnt <= 2 * sent_beats + 200) begin
         @(posedge axi4s_in);
         cycle_cnt++;
      end
      $display("timeout after %0d cycles, %0d packets still expected",
               cycle_cnt, exp_len.size());
      $display("tests failed");
      $finish;
   end

   // ==================================================
   // test sequence.
   // ==================================================
   initial begin
      s_valid = 1'b0;
      s_beat = '0;
      drop_enable = 1'b0;
      drop_pattern = '0;
      drop_mode = drop_mark;
      prefix_words = 3'd0;
      prefix_data = '0;
      trunc_length = '0;
      bp_mode = 1'b0;
      errors = 0;
      errors_at_start = 0;
      tests_run = 0;
      tests_ok = 0;
      sent_beats = 0;
      void'($urandom(32'hd6f2_b949));
      @(negedge srst);
      @(posedge axi4s_in);
      #1;

      for (int n = 1; n <= 40; n++) send_packet(make_packet(n, 1'b0));
      close_test("passthrough");

      prefix_words = 3'd2;
      prefix_data[0] = {$urandom, $urandom};
      prefix_data[1] = {$urandom, $urandom};
      for (int k = 0; k < 10; k++) send_packet(make_packet($urandom_range(40, 1), 1'b0));
      close_test("prefix");

      prefix_words = 3'd0;
      for (int t = 1; t <= 16; t++) begin
         trunc_length = 16'(t);
         for (int k = 0; k < 4; k++) send_packet(make_packet($urandom_range(40, 1), 1'b0));
         drain_pipeline();
      end
      close_test("truncate");

      // even packets match the pattern, odd neighbours do not.
      trunc_length = '0;
      drop_enable = 1'b1;
      drop_mode = drop_mark;
      drop_pattern = {$urandom, $urandom};
      for (int p = 0; p < 2; p++) begin
         prefix_words = 3'(p);
         for (int k = 0; k < 8; k++) begin
            if (k % 2 == 0) begin
               send_packet(make_packet(8 + $urandom_range(24, 0), 1'b1));
            end else begin
               send_packet(make_packet($urandom_range(40, 1), 1'b0));
            end
         end
         drain_pipeline();
      end
      close_test("drop mark");

      drop_mode = drop_whole;
      prefix_words = 3'd2;
      trunc_length = 16'd20;
      for (int k = 0; k < 10; k++) begin
         send_packet(make_packet(k % 2 == 0 ? 8 + $urandom_range(24, 0) : 12, k % 2 == 0));
      end
      close_test("drop whole");

      drop_enable = 1'b0;
      trunc_length = '0;
      bp_mode = 1'b1;
      for (int k = 0; k < 10; k++) send_packet(make_packet($urandom_range(40, 1), 1'b0));
      drain_pipeline();
      prefix_words = 3'd0;
      trunc_length = 16'($urandom_range(16, 1));
      for (int k = 0; k < 10; k++) send_packet(make_packet($urandom_range(40, 1), 1'b0));
      close_test("back-pressure");
      bp_mode = 1'b0;

      $display("%0d of %0d tests ok, %0d errors", tests_ok, tests_run, errors);
      if (errors == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: files.f
design/hdr_proc_pkg.sv
design/hdr_drop_filter.sv
design/hdr_prefix_insert.sv
design/hdr_truncate.sv
design/hdr_pkt_fifo.sv
design/hdr_proc_top.sv
tests/tb_clock_gen.sv
tests/hdr_proc_chk.sv
tests/hdr_proc_tb.sv

// File: run.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and looks for the pass line.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f files.f --top-module hdr_proc_tb -o hdr_proc_sim &&
./obj_dir/hdr_proc_sim | tee /dev/stderr | grep -qx "all tests passed" &&
echo "PASS" || { echo "FAIL"; exit 1; }
